/* cache_array.sv */
// ====================
// direct-mapped line storage
//   valid/dirty bits with reset
//   tag and data words without reset
//   asynchronous read, masked write
// ====================
`timescale 1ns/1ps
`default_nettype none

module cache_array import l1_cache_pkg::*; #(
    parameter int CACHE_SIZE = 1024,
    parameter int BLOCK_SIZE = 2,
    localparam int N_SETS = CACHE_SIZE / (WORD_BYTES * BLOCK_SIZE),
    localparam int IDX_W  = $clog2(N_SETS),
    localparam int TAG_W  = $bits(addr_t) - IDX_W - $clog2(BLOCK_SIZE) - $clog2(WORD_BYTES),
    localparam int DATA_W = $bits(word_t) * BLOCK_SIZE,
    localparam int LINE_W = 2 + TAG_W + DATA_W
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic [IDX_W-1:0]  index,
    input  logic              wen,
    input  logic [LINE_W-1:0] wline,
    input  logic [LINE_W-1:0] wmask, // set bit keeps the old value
    output logic [LINE_W-1:0] rline
);

    localparam int PAY_W   = TAG_W + DATA_W;
    localparam int VALID_B = LINE_W - 1;
    localparam int DIRTY_B = LINE_W - 2;

    logic [N_SETS-1:0] valid_q;
    logic [N_SETS-1:0] dirty_q;
    logic [PAY_W-1:0]  payload [N_SETS]; // tag over data words

    logic [PAY_W-1:0]  pay_new;

    // status bits per set
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wen) begin
            if (!wmask[VALID_B]) begin
                valid_q[index] <= wline[VALID_B];
            end
            if (!wmask[DIRTY_B]) begin
                dirty_q[index] <= wline[DIRTY_B];
            end
        end
    end

    // merge new bits where the mask is clear
    assign pay_new = (payload[index] & wmask[PAY_W-1:0])
                   | (wline[PAY_W-1:0] & ~wmask[PAY_W-1:0]);

    always_ff @(posedge CLK) begin
        if (wen) begin
            payload[index] <= pay_new;
        end
    end

    assign rline = {valid_q[index], dirty_q[index], payload[index]};

endmodule

`default_nettype wire

/* cache_ctrl.sv */
// ====================
// cache controller
//   hit detection and processor reply
//   miss handling, write-back then fill
//   whole-cache flush with pending request
// ====================
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl import l1_cache_pkg::*; #(
    parameter int CACHE_SIZE = 1024,
    parameter int BLOCK_SIZE = 2,
    localparam int N_SETS   = CACHE_SIZE / (WORD_BYTES * BLOCK_SIZE),
    localparam int IDX_W    = $clog2(N_SETS),
    localparam int BLK_BITS = $clog2(BLOCK_SIZE),
    localparam int OFF_W    = BLK_BITS + (BLOCK_SIZE == 1),
    localparam int TAG_W    = $bits(addr_t) - IDX_W - BLK_BITS - $clog2(WORD_BYTES),
    localparam int LINE_W   = 2 + TAG_W + $bits(word_t) * BLOCK_SIZE
) (
    input  logic              CLK,
    input  logic              nRST,
    input  cpu_req_t          cpu_req,
    output cpu_rsp_t          cpu_rsp,
    output mem_req_t          mem_req,
    input  mem_rsp_t          mem_rsp,
    input  logic              flush,
    output logic              flush_done,
    output logic [IDX_W-1:0]  index,
    output logic              wen,
    output logic [LINE_W-1:0] wline,
    output logic [LINE_W-1:0] wmask,
    input  logic [LINE_W-1:0] rline,
    output logic              word_inc,
    output logic              word_clr,
    output logic              flush_step,
    output logic              flush_skip,
    output logic              flush_clr,
    input  logic [OFF_W-1:0]  word_num,
    input  logic              word_last,
    input  logic [IDX_W-1:0]  flush_set,
    input  logic [OFF_W-1:0]  flush_word,
    input  logic              flush_finish
);

    localparam int IDX_LSB = $clog2(WORD_BYTES) + BLK_BITS;
    localparam int TAG_LSB = IDX_LSB + IDX_W;
    localparam logic [OFF_W-1:0] LAST_WORD = OFF_W'(BLOCK_SIZE - 1);

    typedef struct packed {
        logic                   valid;
        logic                   dirty;
        logic [TAG_W-1:0]       tag;
        word_t [BLOCK_SIZE-1:0] data;
    } line_t;

    cache_state_t state, next_state;
    addr_t        addr_q, next_addr; // memory address of the current word
    logic         flush_pend, next_pend;

    line_t cur;  // line at the index
    line_t wr;   // new line bits
    line_t keep; // set bits keep old contents

    logic [TAG_W-1:0] req_tag;
    logic [IDX_W-1:0] req_idx;
    logic [OFF_W-1:0] req_off;
    logic             req, hit, flush_go;

    // byte address of one word in a line
    function automatic addr_t line_addr(input logic [TAG_W-1:0] tag,
                                        input logic [IDX_W-1:0] set,
                                        input logic [OFF_W-1:0] word);
        line_addr = (addr_t'(tag) << TAG_LSB)
                  | (addr_t'(set) << IDX_LSB)
                  | (addr_t'(word) << $clog2(WORD_BYTES));
    endfunction

    // request address fields
    assign req_tag = TAG_W'(cpu_req.addr >> TAG_LSB);
    assign req_idx = IDX_W'(cpu_req.addr >> IDX_LSB);
    assign req_off = OFF_W'(cpu_req.addr >> $clog2(WORD_BYTES)) & LAST_WORD;

    assign cur      = line_t'(rline);
    assign req      = cpu_req.ren | cpu_req.wen;
    assign hit      = cur.valid && (cur.tag == req_tag);
    assign flush_go = flush | flush_pend;

    assign index = (state == FLUSH) ? flush_set : req_idx;
    assign wline = wr;
    assign wmask = keep;

    always_comb begin
        next_state    = state;
        next_addr     = addr_q;
        cpu_rsp.busy  = 1'b1;
        cpu_rsp.rdata = cur.data[req_off];
        mem_req.ren   = 1'b0;
        mem_req.wen   = 1'b0;
        mem_req.addr  = '0;
        mem_req.wdata = '0;
        wen           = 1'b0;
        wr            = '0;
        keep          = '1;
        word_inc      = 1'b0;
        word_clr      = 1'b0;
        flush_step    = 1'b0;
        flush_skip    = 1'b0;
        flush_clr     = 1'b0;
        flush_done    = 1'b0;

        case (state)
            IDLE: begin
                word_clr = 1'b1; // next transfer starts at word 0
                if (flush_go) begin
                    next_state = FLUSH;
                end else if (req && hit) begin
                    cpu_rsp.busy = 1'b0;
                    if (cpu_req.wen) begin
                        wen              = 1'b1;
                        wr.dirty         = 1'b1;
                        keep.dirty       = 1'b0;
                        wr.data[req_off] = cpu_req.wdata;
                        for (int b = 0; b < WORD_BYTES; b++) begin
                            keep.data[req_off][8*b +: 8] = {8{~cpu_req.byte_en[b]}};
                        end
                    end
                end else if (req) begin
                    // miss, the victim is the line at the index
                    if (cur.valid && cur.dirty) begin
                        next_addr  = line_addr(cur.tag, req_idx, '0);
                        next_state = WRITEBACK;
                    end else begin
                        next_addr  = line_addr(req_tag, req_idx, '0);
                        next_state = FETCH;
                    end
                end
            end

            WRITEBACK: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = addr_q;
                mem_req.wdata = cur.data[word_num];
                if (!mem_rsp.busy) begin
                    word_inc  = 1'b1;
                    next_addr = addr_q + addr_t'(WORD_BYTES);
                    if (word_last) begin
                        wen        = 1'b1; // drop the old line
                        keep.valid = 1'b0;
                        keep.dirty = 1'b0;
                        next_addr  = line_addr(req_tag, req_idx, '0);
                        next_state = FETCH;
                    end
                end
            end

            FETCH: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = addr_q;
                if (!mem_rsp.busy) begin
                    word_inc  = 1'b1;
                    next_addr = addr_q + addr_t'(WORD_BYTES);
                    wen       = 1'b1;
                    wr.data[word_num]   = mem_rsp.rdata;
                    keep.data[word_num] = '0;
                    // invalid until the last word lands
                    wr.valid   = word_last;
                    wr.tag     = req_tag;
                    keep.valid = 1'b0;
                    keep.dirty = 1'b0;
                    keep.tag   = '0;
                    if (word_last) begin
                        next_state = IDLE;
                    end
                end
            end

            FLUSH: begin
                if (flush_finish) begin
                    flush_done = 1'b1;
                    flush_clr  = 1'b1;
                    next_state = IDLE;
                end else if (cur.valid && cur.dirty) begin
                    mem_req.wen   = 1'b1;
                    mem_req.addr  = line_addr(cur.tag, flush_set, flush_word);
                    mem_req.wdata = cur.data[flush_word];
                    if (!mem_rsp.busy) begin
                        flush_step = 1'b1;
                        if (flush_word == LAST_WORD) begin
                            wen  = 1'b1; // whole line to zero
                            keep = '0;
                        end
                    end
                end else begin
                    // clean or invalid, clear and move on
                    wen        = 1'b1;
                    keep       = '0;
                    flush_skip = 1'b1;
                end
            end

            default: next_state = IDLE;
        endcase
    end

    // a flush seen during a miss waits for IDLE
    always_comb begin
        next_pend = flush_pend;
        if (state == IDLE) begin
            next_pend = 1'b0;
        end else if (flush && state != FLUSH) begin
            next_pend = 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= IDLE;
            flush_pend <= 1'b0;
        end else begin
            state      <= next_state;
            flush_pend <= next_pend;
        end
    end

    always_ff @(posedge CLK) begin
        addr_q <= next_addr;
    end

endmodule

`default_nettype wire

/* l1_cache.f */
l1_cache_pkg.sv
cache_array.sv
line_counters.sv
cache_ctrl.sv
l1_cache.sv
tb_clock.sv
mem_model.sv
l1_cache_tb.sv

/* l1_cache.sv */
// ====================
// l1 data cache top level
//   controller, line storage, counters
// ====================
`timescale 1ns/1ps
`default_nettype none

module l1_cache import l1_cache_pkg::*; #(
    parameter int CACHE_SIZE = 1024, // bytes, power of two
    parameter int BLOCK_SIZE = 2,    // words per line, up to 8
    localparam int N_SETS = CACHE_SIZE / (WORD_BYTES * BLOCK_SIZE),
    localparam int IDX_W  = $clog2(N_SETS),
    localparam int OFF_W  = $clog2(BLOCK_SIZE) + (BLOCK_SIZE == 1),
    localparam int TAG_W  = $bits(addr_t) - IDX_W - $clog2(BLOCK_SIZE) - $clog2(WORD_BYTES),
    localparam int LINE_W = 2 + TAG_W + $bits(word_t) * BLOCK_SIZE
) (
    input  logic     CLK,
    input  logic     nRST,
    input  cpu_req_t cpu_req,
    output cpu_rsp_t cpu_rsp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp,
    input  logic     flush,
    output logic     flush_done
);

    // array side
    logic [IDX_W-1:0]  index;
    logic              wen;
    logic [LINE_W-1:0] wline;
    logic [LINE_W-1:0] wmask;
    logic [LINE_W-1:0] rline;

    // counter side
    logic             word_inc, word_clr;
    logic             flush_step, flush_skip, flush_clr;
    logic [OFF_W-1:0] word_num;
    logic             word_last;
    logic [IDX_W-1:0] flush_set;
    logic [OFF_W-1:0] flush_word;
    logic             flush_finish;

    cache_ctrl #(
        .CACHE_SIZE(CACHE_SIZE),
        .BLOCK_SIZE(BLOCK_SIZE)
    ) ctrl_inst (.*);

    cache_array #(
        .CACHE_SIZE(CACHE_SIZE),
        .BLOCK_SIZE(BLOCK_SIZE)
    ) array_inst (
        .CLK  (CLK),
        .nRST (nRST),
        .index(index),
        .wen  (wen),
        .wline(wline),
        .wmask(wmask),
        .rline(rline)
    );

    line_counters #(
        .CACHE_SIZE(CACHE_SIZE),
        .BLOCK_SIZE(BLOCK_SIZE)
    ) counters_inst (
        .CLK         (CLK),
        .nRST        (nRST),
        .word_inc    (word_inc),
        .word_clr    (word_clr),
        .flush_step  (flush_step),
        .flush_skip  (flush_skip),
        .flush_clr   (flush_clr),
        .word_num    (word_num),
        .word_last   (word_last),
        .flush_set   (flush_set),
        .flush_word  (flush_word),
        .flush_finish(flush_finish)
    );

endmodule

`default_nettype wire

/* l1_cache_pkg.sv */
// ====================
// shared types for the l1 data cache
//   word, address and byte-enable vectors
//   processor and memory bus structs
//   controller state enum
// ====================
`default_nettype none

package l1_cache_pkg;

    localparam int WORD_BYTES = 4; // bytes per word, address step

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [WORD_BYTES-1:0] byte_en_t; // one enable per byte lane

    // processor request into the cache
    typedef struct packed {
        logic     ren;
        logic     wen;
        addr_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } cpu_req_t;

    // cache reply to the processor
    typedef struct packed {
        logic  busy;
        word_t rdata;
    } cpu_rsp_t;

    // line transfers to memory, whole words only
    typedef struct packed {
        logic  ren;
        logic  wen;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        WRITEBACK,
        FLUSH
    } cache_state_t;

endpackage

`default_nettype wire

/* l1_cache_tb.sv */
// ====================
// l1 cache testbench top
//   clock, reset, DUT and memory model
//   reference memory with byte-lane merge
//   directed hit, miss, eviction and flush tests
//   random read/write mix
// ====================
`timescale 1ns/1ps
`default_nettype none

module l1_cache_tb import l1_cache_pkg::*; ();

    localparam int MEM_WORDS      = 4096;
    localparam int AW             = $clog2(MEM_WORDS);
    localparam int SEED           = 10105;
    localparam int ACCESS_TIMEOUT = 200;  // cycles per processor access
    localparam int FLUSH_TIMEOUT  = 2000; // walker covers every set
    localparam int RANDOM_OPS     = 400;

    logic     CLK;
    logic     nRST;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic     flush;
    logic     flush_done;

    int    seed       = SEED;
    int    errors     = 0;
    int    checks     = 0;
    int    done_count = 0;
    word_t ref_mem [MEM_WORDS]; // expected memory contents
    logic  written [MEM_WORDS];

    mem_req_t prev_req;           // request seen at the last edge
    logic     prev_stall = 1'b0;  // last edge had a stalled transfer

    tb_clock clock_inst (.CLK(CLK));

    l1_cache l1_cache_inst (
        .CLK       (CLK),
        .nRST      (nRST),
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .flush     (flush),
        .flush_done(flush_done)
    );

    mem_model #(
        .MEM_WORDS(MEM_WORDS),
        .SEED     (SEED)
    ) mem_inst (
        .CLK    (CLK),
        .nRST   (nRST),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

    function automatic int mem_index(input addr_t addr);
        mem_index = addr[AW+1:2];
    endfunction

    // each enabled lane takes the new byte
    function automatic word_t merge_lanes(input word_t old_w, input word_t new_w,
                                          input byte_en_t be);
        word_t res;
        res = old_w;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic byte_en_t pick_be(input int k);
        case (k)
            0:       return 4'b0001;
            1:       return 4'b0010;
            2:       return 4'b0100;
            3:       return 4'b1000;
            4:       return 4'b0011;
            5:       return 4'b1100;
            default: return 4'b1111;
        endcase
    endfunction

    task automatic finish_run();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    // one processor access, held until busy drops
    task automatic access(input logic write, input addr_t addr, input word_t wdata,
                          input byte_en_t be, output word_t rdata, output int cycles,
                          output logic ren_done, output logic ren_seen);
        logic done;
        done     = 1'b0;
        cycles   = 0;
        ren_seen = 1'b0;
        @(negedge CLK);
        cpu_req = {~write, write, addr, wdata, be};
        while (!done) begin
            @(posedge CLK);
            ren_seen = ren_seen | mem_req.ren;
            if (!cpu_rsp.busy) begin
                done     = 1'b1;
                rdata    = cpu_rsp.rdata;
                ren_done = mem_req.ren;
            end else if (cycles == ACCESS_TIMEOUT) begin
                $display("timeout waiting for busy low, address %h", addr);
                errors++;
                finish_run();
            end else begin
                cycles++;
            end
        end
        @(negedge CLK);
        cpu_req = '0;
        if (write) begin
            ref_mem[mem_index(addr)] = merge_lanes(ref_mem[mem_index(addr)], wdata, be);
            written[mem_index(addr)] = 1'b1;
        end else begin
            check_word("cpu_rsp.rdata", ref_mem[mem_index(addr)], rdata);
        end
    endtask

    // a stalled transfer holds its request, flush_done count on every clock
    always @(posedge CLK) begin
        if (nRST) begin
            if (prev_stall) begin
                assert (mem_req === prev_req) else begin
                    errors++;
                    $display("[FAIL] mem_req expected %h actual %h", prev_req, mem_req);
                end
            end
            prev_stall = (mem_req.ren || mem_req.wen) && mem_rsp.busy;
            prev_req   = mem_req;
            if (flush_done) begin
                done_count++;
            end
        end else begin
            prev_stall = 1'b0;
        end
    end

    initial begin
        word_t rdata;
        word_t rnd;
        word_t wdata;
        addr_t addr;
        int    cycles;
        logic  ren_done;
        logic  ren_seen;
        logic  seen_done;

        nRST    = 1'b0;
        cpu_req = '0;
        flush   = 1'b0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = mem_inst.store[i]; // preloaded contents
            written[i] = 1'b0;
        end

        @(posedge CLK);
        check_word("cpu_rsp.busy", 1, cpu_rsp.busy);
        check_word("mem_req.ren", 0, mem_req.ren);
        check_word("mem_req.wen", 0, mem_req.wen);
        check_word("flush_done", 0, flush_done);

        // miss then hit on the same word
        access(1'b0, 32'h0000_0040, '0, '0, rdata, cycles, ren_done, ren_seen);
        check_word("mem_req.ren on miss", 1, ren_seen);
        access(1'b0, 32'h0000_0040, '0, '0, rdata, cycles, ren_done, ren_seen);
        check_word("hit wait cycles", 0, cycles);
        check_word("mem_req.ren", 0, ren_done);

        // byte-masked write hits
        access(1'b1, 32'h0000_0040, 32'hDEAD_BEEF, 4'b0011, rdata, cycles, ren_done, ren_seen);
        access(1'b0, 32'h0000_0040, '0, '0, rdata, cycles, ren_done, ren_seen);
        access(1'b1, 32'h0000_0044, 32'h1234_5678, 4'b0100, rdata, cycles, ren_done, ren_seen);
        access(1'b0, 32'h0000_0044, '0, '0, rdata, cycles, ren_done, ren_seen);

        // dirty victim, same index with another tag
        access(1'b1, 32'h0000_0080, 32'hCAFE_F00D, 4'b1100, rdata, cycles, ren_done, ren_seen);
        access(1'b0, 32'h0000_0480, '0, '0, rdata, cycles, ren_done, ren_seen);
        check_word("mem store at victim", ref_mem[mem_index(32'h80)],
                   mem_inst.store[mem_index(32'h80)]);

        // dirty some lines, then flush
        for (int i = 0; i < 6; i++) begin
            wdata = $random(seed);
            access(1'b1, 32'h0000_0100 + i * 40, wdata, 4'b1111, rdata, cycles,
                   ren_done, ren_seen);
        end
        @(negedge CLK);
        flush = 1'b1;
        @(negedge CLK);
        flush     = 1'b0;
        seen_done = 1'b0;
        cycles    = 0;
        while (!seen_done) begin
            @(posedge CLK);
            if (flush_done) begin
                seen_done = 1'b1;
            end else if (cycles == FLUSH_TIMEOUT) begin
                $display("timeout waiting for flush_done");
                errors++;
                finish_run();
            end else begin
                cycles++;
            end
        end
        repeat (20) @(negedge CLK);
        check_word("flush_done pulses", 1, done_count);
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (written[i]) begin
                check_word("mem store after flush", ref_mem[i], mem_inst.store[i]);
            end
        end
        access(1'b0, 32'h0000_0100, '0, '0, rdata, cycles, ren_done, ren_seen);
        check_word("mem_req.ren after flush", 1, ren_seen);

        // random mix over 4 tags and 8 sets
        for (int n = 0; n < RANDOM_OPS; n++) begin
            rnd   = $random(seed);
            wdata = $random(seed);
            addr  = {20'h0, rnd[1:0], 4'h0, rnd[4:2], rnd[5], 2'b00};
            access(rnd[6], addr, wdata, pick_be(rnd[10:8] % 7), rdata, cycles,
                   ren_done, ren_seen);
        end

        finish_run();
    end

endmodule

`default_nettype wire

/* line_counters.sv */
// ====================
// transfer counters
//   word counter for fills and write-backs
//   flush walker over sets and words
// ====================
`timescale 1ns/1ps
`default_nettype none

module line_counters import l1_cache_pkg::*; #(
    parameter int CACHE_SIZE = 1024,
    parameter int BLOCK_SIZE = 2,
    localparam int N_SETS = CACHE_SIZE / (WORD_BYTES * BLOCK_SIZE),
    localparam int IDX_W  = $clog2(N_SETS),
    localparam int OFF_W  = $clog2(BLOCK_SIZE) + (BLOCK_SIZE == 1)
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             word_inc,
    input  logic             word_clr,
    input  logic             flush_step,
    input  logic             flush_skip,
    input  logic             flush_clr,
    output logic [OFF_W-1:0] word_num,
    output logic             word_last,
    output logic [IDX_W-1:0] flush_set,
    output logic [OFF_W-1:0] flush_word,
    output logic             flush_finish
);

    localparam logic [OFF_W-1:0] LAST_WORD = OFF_W'(BLOCK_SIZE - 1);

    logic flush_word_last;

    assign word_last       = (word_num == LAST_WORD);
    assign flush_word_last = (flush_word == LAST_WORD);

    // wraps to zero after the last word of a line
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            word_num <= '0;
        end else if (word_clr) begin
            word_num <= '0;
        end else if (word_inc) begin
            word_num <= word_last ? '0 : word_num + 1'b1;
        end
    end

    // finish is the carry out of the set count
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            flush_finish <= 1'b0;
            flush_set    <= '0;
            flush_word   <= '0;
        end else if (flush_clr) begin
            flush_finish <= 1'b0;
            flush_set    <= '0;
            flush_word   <= '0;
        end else if (flush_skip || (flush_step && flush_word_last)) begin
            flush_word                <= '0;
            {flush_finish, flush_set} <= {flush_finish, flush_set} + 1'b1;
        end else if (flush_step) begin
            flush_word <= flush_word + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* mem_model.sv */
// ====================
// testbench memory
//   word store with an address-based fill
//   random busy stalls from a seeded generator
//   combinational read, write on the clock edge
// ====================
`timescale 1ns/1ps
`default_nettype none

module mem_model import l1_cache_pkg::*; #(
    parameter int MEM_WORDS = 4096,
    parameter int SEED      = 10105
) (
    input  logic     CLK,
    input  logic     nRST,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    localparam int AW = $clog2(MEM_WORDS);

    word_t         store [MEM_WORDS]; // also read by the testbench top
    logic          stall_q;
    logic [AW-1:0] widx;
    int            seed = SEED;

    // fill value depends on every word address bit
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            store[i] = (word_t'(i) * 32'h9E37_79B9) ^ 32'h5A5A_C3C3;
        end
    end

    assign widx    = mem_req.addr[AW+1:2]; // word address
    assign mem_rsp = {stall_q, store[widx]};

    // stall roughly one cycle in four
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            stall_q <= 1'b1;
        end else begin
            stall_q <= (($random(seed) & 3) == 0);
        end
    end

    // a write lands in a cycle without stall
    always @(posedge CLK) begin
        if (mem_req.wen && !stall_q) begin
            store[widx] <= mem_req.wdata;
        end
    end

endmodule

`default_nettype wire

/* tb_clock.sv */
// ====================
// testbench clock source
//   free-running clock, 8 ns period
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD = 8.0
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
        forever begin
            #(PERIOD / 2.0) CLK = ~CLK; // half period per phase
        end
    end

endmodule

`default_nettype wire
